// ==== files.f ====
+incdir+testbench
design/isa_pkg.sv
design/core_pkg.sv
design/stage_if.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/hazard_unit.sv
design/execute_unit.sv
design/memory_unit.sv
design/mips_pipeline.sv
testbench/tb_mips_pipeline.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - design/isa_pkg.sv
  - design/core_pkg.sv
  - design/stage_if.sv
  - design/fetch_unit.sv
  - design/reg_file.sv
  - design/decode_unit.sv
  - design/hazard_unit.sv
  - design/execute_unit.sv
  - design/memory_unit.sv
  - design/mips_pipeline.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mips_pipeline.sv

// ==== testbench/tb_isa_encode.svh ====
/* Program-building helpers for the pipeline testbench, included inside its module.
   Encodes MIPS words, draws LFSR immediates and loads programs through the imem port. */
`ifndef TB_ISA_ENCODE_SVH
`define TB_ISA_ENCODE_SVH

// MIPS sign extension of a 16-bit immediate
function automatic word_t sign_extend(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
endfunction

// fibonacci lfsr, one step per bit taken
function automatic logic [15:0] random_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        fb         = ^(lfsr_state & 32'h8020_0003);  // taps 32, 22, 2, 1
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[14:0], fb};
    end
    return v;
endfunction

function automatic instr_t r_type(input funct_t fn, input reg_idx_t rd,
                                  input reg_idx_t rs, input reg_idx_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic instr_t i_type(input opcode_t op, input reg_idx_t rt,
                                  input reg_idx_t rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic emit(input instr_t word);
    prog.push_back(word);
endtask

// completion marker in r31, then spin on a branch to itself
task automatic close_program;
    emit(i_type(OP_ADDI, 5'd31, 5'd0, MARKER));
    emit(i_type(OP_BEQ, 5'd0, 5'd0, 16'hffff));
endtask

task automatic load_program;
    for (int i = 0; i < prog.size(); i++)
    begin
        @(negedge SYS_clk);
        imem_wr_en   = 1'b1;
        imem_wr_addr = i[IMEM_AW-1:0];
        imem_wr_data = prog[i];
    end
    @(negedge SYS_clk);
    imem_wr_en = 1'b0;
endtask

`endif

// ==== testbench/tb_mips_pipeline.sv ====
/* Directed testbench for the five-stage MIPS pipeline. Each test loads a program,
   waits for the marker in r31 and checks registers against sequential MIPS results. */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int          POLL_LIMIT  = 300;
    localparam logic [15:0] MARKER      = 16'h3c5a;
    localparam word_t       MARKER_WORD = 32'h0000_3c5a;
    localparam logic [15:0] SKIP_IMM    = 16'h0bad;  // value only a wrong-path write would leave

    logic        SYS_clk;
    logic        SYS_reset;
    logic        imem_wr_en;
    imem_addr_t  imem_wr_addr;
    instr_t      imem_wr_data;
    reg_idx_t    dbg_reg_addr;
    word_t       dbg_reg_data;

    instr_t      prog [$];
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    `include "tb_isa_encode.svh"

    mips_pipeline u_dut (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #4 SYS_clk = ~SYS_clk;
    end

    task automatic read_reg(input reg_idx_t idx, output word_t value);
        @(negedge SYS_clk);
        dbg_reg_addr = idx;
        #1 value = dbg_reg_data;  // regs only change at the rising edge
    endtask

    task automatic check_reg(input string test, input reg_idx_t idx, input word_t expected);
        word_t got;
        read_reg(idx, got);
        checks++;
        if (got !== expected)
        begin
            $display("Mismatch %s: dbg_reg_data for r%0d = 0x%08h, expected 0x%08h",
                     test, idx, got, expected);
            errors++;
        end
    endtask

    task automatic wait_for_marker(input string test);
        word_t value;
        int    cycles;
        value  = '0;
        cycles = 0;
        while (value !== MARKER_WORD && cycles < POLL_LIMIT)
        begin
            read_reg(5'd31, value);
            cycles++;
        end
        if (value !== MARKER_WORD)
        begin
            $display("Timeout in %s: r31 never reached the completion marker", test);
            errors++;
        end
    endtask

    // hold reset while loading, then release and wait for completion
    task automatic run_program(input string test);
        @(negedge SYS_clk);
        SYS_reset = 1'b1;
        load_program();
        repeat (5) @(negedge SYS_clk);
        SYS_reset = 1'b0;
        wait_for_marker(test);
    endtask

    task automatic alu_ops_test;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        word_t       a;
        word_t       b;
        imm_a = random_bits(16);
        imm_b = random_bits(16);
        a     = sign_extend(imm_a);
        b     = sign_extend(imm_b);
        prog.delete();
        emit(i_type(OP_ADDI, 5'd1, 5'd0, imm_a));
        emit(i_type(OP_ADDI, 5'd2, 5'd0, imm_b));
        emit(r_type(FN_ADD, 5'd3, 5'd1, 5'd2));
        emit(r_type(FN_SUB, 5'd4, 5'd1, 5'd2));
        emit(r_type(FN_AND, 5'd5, 5'd1, 5'd2));
        emit(r_type(FN_OR, 5'd6, 5'd1, 5'd2));
        emit(r_type(FN_SLT, 5'd7, 5'd1, 5'd2));
        emit(r_type(FN_SLT, 5'd8, 5'd2, 5'd1));  // both orders of the signed compare
        close_program();
        run_program("alu ops");
        check_reg("alu ops", 5'd3, a + b);
        check_reg("alu ops", 5'd4, a - b);
        check_reg("alu ops", 5'd5, a & b);
        check_reg("alu ops", 5'd6, a | b);
        check_reg("alu ops", 5'd7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        check_reg("alu ops", 5'd8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    endtask

    task automatic dependent_chain_test;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        word_t       a;
        word_t       b;
        word_t       c [3:9];
        imm_a = random_bits(16);
        imm_b = random_bits(16);
        a     = sign_extend(imm_a);
        b     = sign_extend(imm_b);
        c[3]  = a + b;
        c[4]  = c[3] + c[3];
        c[5]  = c[4] - a;
        c[6]  = c[5] | c[4];
        c[7]  = c[6] & c[6];
        c[8]  = ($signed(c[7]) < $signed(c[3])) ? 32'd1 : 32'd0;
        c[9]  = c[8] + c[7];
        prog.delete();
        emit(i_type(OP_ADDI, 5'd1, 5'd0, imm_a));
        emit(i_type(OP_ADDI, 5'd2, 5'd0, imm_b));
        emit(r_type(FN_ADD, 5'd3, 5'd1, 5'd2));
        emit(r_type(FN_ADD, 5'd4, 5'd3, 5'd3));  // both operands from one producer
        emit(r_type(FN_SUB, 5'd5, 5'd4, 5'd1));
        emit(r_type(FN_OR, 5'd6, 5'd5, 5'd4));
        emit(r_type(FN_AND, 5'd7, 5'd6, 5'd6));
        emit(r_type(FN_SLT, 5'd8, 5'd7, 5'd3));
        emit(r_type(FN_ADD, 5'd9, 5'd8, 5'd7));
        close_program();
        run_program("dependent chain");
        for (int i = 3; i <= 9; i++)
            check_reg("dependent chain", i[4:0], c[i]);
    endtask

    task automatic load_store_test;
        logic [15:0] base;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        base  = random_bits(8) << 2;  // word aligned, below 1 KiB
        imm_a = random_bits(16);
        imm_b = random_bits(16);
        prog.delete();
        emit(i_type(OP_ADDI, 5'd1, 5'd0, base));
        emit(i_type(OP_ADDI, 5'd2, 5'd0, imm_a));
        emit(i_type(OP_ADDI, 5'd3, 5'd0, imm_b));
        emit(i_type(OP_SW, 5'd2, 5'd1, 16'd0));
        emit(i_type(OP_LW, 5'd4, 5'd1, 16'd0));  // same address
        emit(i_type(OP_SW, 5'd3, 5'd1, 16'd8));
        emit(i_type(OP_LW, 5'd5, 5'd1, 16'd8));
        emit(i_type(OP_LW, 5'd6, 5'd1, 16'd0));  // earlier word untouched
        emit(r_type(FN_ADD, 5'd7, 5'd6, 5'd5));  // load-use
        close_program();
        run_program("load store");
        check_reg("load store", 5'd4, sign_extend(imm_a));
        check_reg("load store", 5'd5, sign_extend(imm_b));
        check_reg("load store", 5'd6, sign_extend(imm_a));
        check_reg("load store", 5'd7, sign_extend(imm_a) + sign_extend(imm_b));
    endtask

    task automatic branch_test;
        logic [15:0] imm_a;
        logic [15:0] imm_x;
        logic [15:0] imm_y;
        logic [15:0] imm_z;
        logic [15:0] imm_p;
        imm_a = random_bits(16);
        imm_x = imm_a ^ 16'h0010;  // always differs from imm_a
        imm_y = random_bits(16) | 16'h0001;
        imm_z = random_bits(16) | 16'h0001;
        imm_p = random_bits(16) | 16'h0001;
        prog.delete();
        emit(i_type(OP_ADDI, 5'd3, 5'd0, imm_p));
        emit(i_type(OP_ADDI, 5'd1, 5'd0, imm_a));
        emit(i_type(OP_ADDI, 5'd2, 5'd0, imm_a));
        emit(i_type(OP_BEQ, 5'd2, 5'd1, 16'd2));      // taken, skips two
        emit(i_type(OP_ADDI, 5'd3, 5'd0, SKIP_IMM));
        emit(i_type(OP_ADDI, 5'd8, 5'd0, SKIP_IMM));
        emit(i_type(OP_ADDI, 5'd4, 5'd0, imm_x));
        emit(i_type(OP_BNE, 5'd4, 5'd1, 16'd1));      // taken
        emit(i_type(OP_ADDI, 5'd5, 5'd0, SKIP_IMM));
        emit(i_type(OP_BEQ, 5'd4, 5'd1, 16'd1));      // not taken
        emit(i_type(OP_ADDI, 5'd6, 5'd0, imm_y));
        emit(i_type(OP_BNE, 5'd2, 5'd1, 16'd1));      // not taken
        emit(i_type(OP_ADDI, 5'd7, 5'd0, imm_z));
        close_program();
        run_program("branch");
        check_reg("branch", 5'd3, sign_extend(imm_p));
        check_reg("branch", 5'd8, '0);
        check_reg("branch", 5'd4, sign_extend(imm_x));
        check_reg("branch", 5'd5, '0);
        check_reg("branch", 5'd6, sign_extend(imm_y));
        check_reg("branch", 5'd7, sign_extend(imm_z));
    endtask

    task automatic zero_reg_test;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        imm_a = random_bits(16) | 16'h0100;
        imm_b = random_bits(16) | 16'h0001;
        prog.delete();
        emit(i_type(OP_ADDI, 5'd1, 5'd0, imm_a));
        emit(i_type(OP_ADDI, 5'd0, 5'd0, imm_b));
        emit(r_type(FN_ADD, 5'd2, 5'd0, 5'd1));  // must not see imm_b
        emit(r_type(FN_ADD, 5'd0, 5'd1, 5'd1));
        emit(r_type(FN_ADD, 5'd3, 5'd0, 5'd0));
        emit(r_type(FN_OR, 5'd4, 5'd0, 5'd1));
        close_program();
        run_program("zero register");
        check_reg("zero register", 5'd0, '0);
        check_reg("zero register", 5'd2, sign_extend(imm_a));
        check_reg("zero register", 5'd3, '0);
        check_reg("zero register", 5'd4, sign_extend(imm_a));
    endtask

    task automatic second_reset_test;
        logic [15:0] vals [1:30];
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        prog.delete();
        for (int i = 1; i <= 30; i++)
        begin
            vals[i] = random_bits(16) | 16'h0001;
            emit(i_type(OP_ADDI, i[4:0], 5'd0, vals[i]));
        end
        close_program();
        run_program("second reset, first run");
        for (int i = 1; i <= 30; i++)
            check_reg("second reset, first run", i[4:0], sign_extend(vals[i]));
        @(negedge SYS_clk);
        SYS_reset = 1'b1;
        repeat (5) @(negedge SYS_clk);
        for (int i = 0; i < 32; i++)
            check_reg("second reset, cleared", i[4:0], '0);
        imm_a = random_bits(16);
        imm_b = random_bits(16);
        prog.delete();
        emit(i_type(OP_ADDI, 5'd1, 5'd0, imm_a));
        emit(i_type(OP_ADDI, 5'd2, 5'd0, imm_b));
        emit(r_type(FN_SUB, 5'd3, 5'd1, 5'd2));
        close_program();
        run_program("second reset, new program");
        check_reg("second reset, new program", 5'd3, sign_extend(imm_a) - sign_extend(imm_b));
        check_reg("second reset, new program", 5'd30, '0);  // old words past the spin never run
    endtask

    initial
    begin
        SYS_reset    = 1'b1;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        dbg_reg_addr = '0;
        lfsr_state   = 32'hb51;
        errors       = 0;
        checks       = 0;
        repeat (5) @(negedge SYS_clk);
        alu_ops_test();
        dependent_chain_test();
        load_store_test();
        branch_test();
        zero_reg_test();
        second_reset_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/mips_pipeline.sv ====
/* Top level of the five-stage MIPS pipeline. Programs are loaded through the
   instruction-memory write port and registers are observed through the debug port. */
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline (
    input  wire                       SYS_clk,
    input  wire                       SYS_reset,
    input  wire                       imem_wr_en,
    input  wire core_pkg::imem_addr_t imem_wr_addr,
    input  wire isa_pkg::instr_t      imem_wr_data,
    input  wire isa_pkg::reg_idx_t    dbg_reg_addr,
    output wire core_pkg::word_t      dbg_reg_data
);
    import core_pkg::*;
    import isa_pkg::*;

    instr_t   if_instr;
    word_t    if_pc;
    logic     branch_taken;
    word_t    branch_target;
    logic     stall, fwd_rs, fwd_rt;
    word_t    fwd_data;
    reg_idx_t id_rs, id_rt;
    logic     id_uses_rt;
    logic     wb_en;
    reg_idx_t wb_dest;
    word_t    wb_data;

    dx_if dx ();
    xm_if xm ();

    fetch_unit u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .imem_wr_en    (imem_wr_en),
        .imem_wr_addr  (imem_wr_addr),
        .imem_wr_data  (imem_wr_data),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .if_instr      (if_instr),
        .if_pc         (if_pc)
    );

    decode_unit u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .fwd_data      (fwd_data),
        .wb_en         (wb_en),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .dbg_reg_addr  (dbg_reg_addr),
        .dbg_reg_data  (dbg_reg_data),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_uses_rt    (id_uses_rt),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .dx            (dx.producer)
    );

    hazard_unit u_hazard (
        .id_rs      (id_rs),
        .id_rt      (id_rt),
        .id_uses_rt (id_uses_rt),
        .dx         (dx.monitor),
        .xm         (xm.monitor),
        .stall      (stall),
        .fwd_rs     (fwd_rs),
        .fwd_rt     (fwd_rt),
        .fwd_data   (fwd_data)
    );

    execute_unit u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .dx        (dx.consumer),
        .xm        (xm.producer)
    );

    memory_unit u_memory (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .xm        (xm.consumer),
        .wb_en     (wb_en),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

// ==== design/memory_unit.sv ====
/* Memory stage with the data memory and the memory/writeback register.
   Drives the register-file write port, choosing load data or the ALU result. */
`timescale 1ns/1ps
`default_nettype none

module memory_unit (
    input  wire               SYS_clk,
    input  wire               SYS_reset,
    xm_if.consumer            xm,
    output logic              wb_en,
    output isa_pkg::reg_idx_t wb_dest,
    output core_pkg::word_t   wb_data
);
    import core_pkg::*;

    word_t                dmem [2**DMEM_AW];
    logic [DMEM_AW-1:0]   dmem_idx;
    word_t                load_data;
    word_t                mw_load_data;
    word_t                mw_alu_result;
    logic                 mw_to_reg;

    assign dmem_idx  = xm.alu_result[DMEM_AW+1:2];  // word address
    assign load_data = xm.mem_read ? dmem[dmem_idx] : '0;

    always_ff @(posedge SYS_clk)
    begin
        if (xm.mem_write)
            dmem[dmem_idx] <= xm.store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_en     <= 1'b0;
            wb_dest   <= '0;
            mw_to_reg <= 1'b0;
        end
        else
        begin
            wb_en     <= xm.reg_write;
            wb_dest   <= xm.dest;
            mw_to_reg <= xm.mem_to_reg;
        end
        mw_load_data  <= load_data;
        mw_alu_result <= xm.alu_result;
    end

    assign wb_data = mw_to_reg ? mw_load_data : mw_alu_result;

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
/* Execute stage: operand select, the five-operation ALU and the execute/memory
   register that carries the result and remaining controls to memory. */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire   SYS_clk,
    input  wire   SYS_reset,
    dx_if.consumer dx,
    xm_if.producer xm
);
    import core_pkg::*;

    word_t op_b;
    word_t alu_result;

    assign op_b = dx.alu_src_imm ? dx.imm : dx.rt_val;

    always_comb
    begin
        case (dx.alu_sel)
            ALU_ADD: alu_result = dx.rs_val + op_b;
            ALU_SUB: alu_result = dx.rs_val - op_b;
            ALU_AND: alu_result = dx.rs_val & op_b;
            ALU_OR:  alu_result = dx.rs_val | op_b;
            ALU_SLT: alu_result = {31'b0, $signed(dx.rs_val) < $signed(op_b)};  // signed
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            xm.reg_write  <= 1'b0;
            xm.mem_read   <= 1'b0;
            xm.mem_write  <= 1'b0;
            xm.mem_to_reg <= 1'b0;
            xm.dest       <= '0;
        end
        else
        begin
            xm.reg_write  <= dx.reg_write;
            xm.mem_read   <= dx.mem_read;
            xm.mem_write  <= dx.mem_write;
            xm.mem_to_reg <= dx.mem_to_reg;
            xm.dest       <= dx.dest;
        end
        xm.alu_result <= alu_result;
        xm.store_data <= dx.rt_val;
    end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
/* Hazard detection for the decode stage. Stalls on results not yet available
   and selects memory-stage ALU results for forwarding into decode. */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire isa_pkg::reg_idx_t id_rs,
    input  wire isa_pkg::reg_idx_t id_rt,
    input  wire                    id_uses_rt,
    dx_if.monitor                  dx,
    xm_if.monitor                  xm,
    output logic                   stall,
    output logic                   fwd_rs,
    output logic                   fwd_rt,
    output core_pkg::word_t        fwd_data
);
    import isa_pkg::*;

    logic ex_busy, mem_load, mem_alu;

    // r0 never matches
    function automatic logic hit(input reg_idx_t dest, input reg_idx_t src);
        return (dest != '0) && (dest == src);
    endfunction

    function automatic logic reads(input reg_idx_t dest, input reg_idx_t rs,
                                   input reg_idx_t rt, input logic uses_rt);
        return hit(dest, rs) || (uses_rt && hit(dest, rt));
    endfunction

    assign ex_busy  = dx.reg_write || dx.mem_read;    // result not computed yet
    assign mem_load = xm.reg_write && xm.mem_to_reg;  // load data arrives next cycle
    assign mem_alu  = xm.reg_write && !xm.mem_to_reg;

    assign stall = (ex_busy && reads(dx.dest, id_rs, id_rt, id_uses_rt)) ||
                   (mem_load && reads(xm.dest, id_rs, id_rt, id_uses_rt));

    assign fwd_rs   = mem_alu && hit(xm.dest, id_rs);
    assign fwd_rt   = mem_alu && id_uses_rt && hit(xm.dest, id_rt);
    assign fwd_data = xm.alu_result;

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
/* Decode stage: control decode, operand select with memory-stage forwarding,
   early branch resolution and the decode/execute register. */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire                    SYS_clk,
    input  wire                    SYS_reset,
    input  wire isa_pkg::instr_t   if_instr,
    input  wire core_pkg::word_t   if_pc,
    input  wire                    stall,
    input  wire                    fwd_rs,
    input  wire                    fwd_rt,
    input  wire core_pkg::word_t   fwd_data,
    input  wire                    wb_en,
    input  wire isa_pkg::reg_idx_t wb_dest,
    input  wire core_pkg::word_t   wb_data,
    input  wire isa_pkg::reg_idx_t dbg_reg_addr,
    output core_pkg::word_t        dbg_reg_data,
    output isa_pkg::reg_idx_t      id_rs,
    output isa_pkg::reg_idx_t      id_rt,
    output logic                   id_uses_rt,
    output logic                   branch_taken,
    output core_pkg::word_t        branch_target,
    dx_if.producer                 dx
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd;
    word_t    imm;
    word_t    file_rs, file_rt;
    word_t    rs_val, rt_val;
    logic     reg_write, mem_read, mem_write, mem_to_reg, alu_src_imm, dest_is_rd;
    alu_sel_t alu_sel;

    assign opcode = if_instr[OPCODE_LSB +: OPCODE_W];
    assign funct  = if_instr[FUNCT_W-1:0];
    assign id_rs  = if_instr[RS_LSB +: REG_IDX_W];
    assign id_rt  = if_instr[RT_LSB +: REG_IDX_W];
    assign rd     = if_instr[RD_LSB +: REG_IDX_W];
    assign imm    = word_t'($signed(if_instr[IMM_W-1:0]));

    always_comb
    begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        alu_src_imm = 1'b0;
        dest_is_rd  = 1'b0;
        id_uses_rt  = 1'b0;
        alu_sel     = ALU_ADD;
        case (opcode)
            OP_RTYPE:
            begin
                dest_is_rd = 1'b1;
                id_uses_rt = 1'b1;
                reg_write  = 1'b1;
                case (funct)
                    FN_ADD:  alu_sel = ALU_ADD;
                    FN_SUB:  alu_sel = ALU_SUB;
                    FN_AND:  alu_sel = ALU_AND;
                    FN_OR:   alu_sel = ALU_OR;
                    FN_SLT:  alu_sel = ALU_SLT;
                    default: reg_write = 1'b0;  // nop and unsupported functions
                endcase
            end
            OP_ADDI:
            begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                mem_to_reg  = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                id_uses_rt  = 1'b1;  // store data read here
            end
            OP_BEQ, OP_BNE:
                id_uses_rt = 1'b1;
            default: ;
        endcase
    end

    reg_file u_reg_file (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .rd_addr_a    (id_rs),
        .rd_addr_b    (id_rt),
        .rd_data_a    (file_rs),
        .rd_data_b    (file_rt),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .wb_en        (wb_en),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data)
    );

    assign rs_val = fwd_rs ? fwd_data : file_rs;
    assign rt_val = fwd_rt ? fwd_data : file_rt;

    // branch resolves here, so the fetch behind it is the only wrong-path slot
    assign branch_taken  = (opcode == OP_BEQ && rs_val == rt_val) ||
                           (opcode == OP_BNE && rs_val != rt_val);
    assign branch_target = if_pc + 32'd4 + {imm[29:0], 2'b00};

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)  // bubble
        begin
            dx.reg_write   <= 1'b0;
            dx.mem_read    <= 1'b0;
            dx.mem_write   <= 1'b0;
            dx.mem_to_reg  <= 1'b0;
            dx.alu_src_imm <= 1'b0;
            dx.alu_sel     <= ALU_ADD;
            dx.dest        <= '0;
        end
        else
        begin
            dx.reg_write   <= reg_write;
            dx.mem_read    <= mem_read;
            dx.mem_write   <= mem_write;
            dx.mem_to_reg  <= mem_to_reg;
            dx.alu_src_imm <= alu_src_imm;
            dx.alu_sel     <= alu_sel;
            dx.dest        <= dest_is_rd ? rd : id_rt;
        end
        dx.rs_val <= rs_val;
        dx.rt_val <= rt_val;
        dx.imm    <= imm;
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
/* 32-entry register file read in decode and written at the end of writeback.
   A read of the register being written returns the new value. */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                   SYS_clk,
    input  wire                   SYS_reset,
    input  wire isa_pkg::reg_idx_t rd_addr_a,
    input  wire isa_pkg::reg_idx_t rd_addr_b,
    output core_pkg::word_t       rd_data_a,
    output core_pkg::word_t       rd_data_b,
    input  wire isa_pkg::reg_idx_t dbg_reg_addr,
    output core_pkg::word_t       dbg_reg_data,
    input  wire                   wb_en,
    input  wire isa_pkg::reg_idx_t wb_dest,
    input  wire core_pkg::word_t  wb_data
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t regs [32];

    function automatic word_t read_port(input reg_idx_t addr, input word_t stored,
                                        input logic we, input reg_idx_t wa, input word_t wd);
        if (addr == '0)
            return '0;
        if (we && wa == addr)
            return wd;  // same-cycle writeback
        return stored;
    endfunction

    assign rd_data_a    = read_port(rd_addr_a, regs[rd_addr_a], wb_en, wb_dest, wb_data);
    assign rd_data_b    = read_port(rd_addr_b, regs[rd_addr_b], wb_en, wb_dest, wb_data);
    assign dbg_reg_data = read_port(dbg_reg_addr, regs[dbg_reg_addr], wb_en, wb_dest, wb_data);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_en && wb_dest != '0)  // r0 stays zero
            regs[wb_dest] <= wb_data;
    end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
/* Fetch stage with the program counter and the loadable instruction memory.
   Feeds the fetch/decode register, which holds on stall and clears on a taken branch. */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                      SYS_clk,
    input  wire                      SYS_reset,
    input  wire                      imem_wr_en,
    input  wire core_pkg::imem_addr_t imem_wr_addr,
    input  wire isa_pkg::instr_t     imem_wr_data,
    input  wire                      stall,
    input  wire                      branch_taken,
    input  wire core_pkg::word_t     branch_target,
    output isa_pkg::instr_t          if_instr,
    output core_pkg::word_t          if_pc
);
    import core_pkg::*;
    import isa_pkg::*;

    instr_t     imem [2**IMEM_AW];
    word_t      pc;
    imem_addr_t pc_idx;

    assign pc_idx = pc[IMEM_AW+1:2];  // word index

    // program load port, independent of reset
    always_ff @(posedge SYS_clk)
    begin
        if (imem_wr_en)
            imem[imem_wr_addr] <= imem_wr_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc       <= RESET_PC;
            if_instr <= NOP_INSTR;
        end
        else if (!stall)  // stall holds pc and the f/d register
        begin
            if (branch_taken)
            begin
                pc       <= branch_target;
                if_instr <= NOP_INSTR;  // kill the wrong-path fetch
            end
            else
            begin
                pc       <= pc + 32'd4;
                if_instr <= imem[pc_idx];
            end
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            if_pc <= pc;
    end

endmodule

`default_nettype wire

// ==== design/stage_if.sv ====
/* Stage-register bundles between decode and execute and between execute and memory.
   The hazard unit taps both through read-only monitor views. */
`timescale 1ns/1ps
`default_nettype none

interface dx_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     alu_src_imm;  // second operand is the immediate
    alu_sel_t alu_sel;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm;
    reg_idx_t dest;

    modport producer (
        output reg_write, mem_read, mem_write, mem_to_reg, alu_src_imm, alu_sel,
        output rs_val, rt_val, imm, dest
    );
    modport consumer (
        input reg_write, mem_read, mem_write, mem_to_reg, alu_src_imm, alu_sel,
        input rs_val, rt_val, imm, dest
    );
    modport monitor (input dest, reg_write, mem_read);
endinterface

interface xm_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    word_t    alu_result;  // also the data address
    word_t    store_data;
    reg_idx_t dest;

    modport producer (
        output reg_write, mem_read, mem_write, mem_to_reg, alu_result, store_data, dest
    );
    modport consumer (
        input reg_write, mem_read, mem_write, mem_to_reg, alu_result, store_data, dest
    );
    modport monitor (input dest, reg_write, mem_to_reg, alu_result);
endinterface

`default_nettype wire

// ==== design/core_pkg.sv ====
/* Datapath widths, memory sizes, reset vector and ALU operation codes of the core.
   Imported by the pipeline stages and by the testbench. */
`default_nettype none

package core_pkg;

    localparam int WORD_W  = 32;
    localparam int IMEM_AW = 8;   // 256 instruction words
    localparam int DMEM_AW = 8;   // 256 data words

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [IMEM_AW-1:0] imem_addr_t;
    typedef logic [2:0]         alu_sel_t;

    localparam word_t RESET_PC = 32'h0040_0000;

    localparam alu_sel_t ALU_ADD = 3'd0;
    localparam alu_sel_t ALU_SUB = 3'd1;
    localparam alu_sel_t ALU_AND = 3'd2;
    localparam alu_sel_t ALU_OR  = 3'd3;
    localparam alu_sel_t ALU_SLT = 3'd4;

endpackage

`default_nettype wire

// ==== design/isa_pkg.sv ====
/* MIPS instruction-set definitions shared by the decoder and the program encoders.
   Holds opcode and function codes, field positions and register-index types. */
`default_nettype none

package isa_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_IDX_W  = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;

    // bit positions of the instruction fields
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;

    typedef logic [INSTR_W-1:0]   instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNCT_W-1:0]   funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2B;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2A;

    localparam instr_t NOP_INSTR = '0;  // sll r0, r0, 0 acts as a bubble

endpackage

`default_nettype wire
